// File: all.f
mem_pipe_pkg.sv
mem_dtlb.sv
mem_fault_check.sv
mem_dmem.sv
mem_pipe.sv
mem_pipe_checker.sv
mem_pipe_assert.sv
tb_mem_pipe.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_pipe
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_mem_pipe.sv
// Testbench top for the memory pipe, drives LFSR stimulus and a reference model
`timescale 1ns/100ps

module tb_mem_pipe;

  logic                             clk_i;
  logic                             reset_i;
  logic                             res_v_i;
  mem_pipe_pkg::mem_reservation_s   res_i;
  logic                             fill_v_i;
  mem_pipe_pkg::tlb_fill_s          fill_i;
  logic                             sfence_i;
  mem_pipe_pkg::trans_info_s        trans_info_i;
  logic                             result_v_o;
  mem_pipe_pkg::mem_result_s        result_o;

  logic [31:0]                      lfsr_state = 32'h2eeb_5a85;
  logic [63:0]                      shadow_mem [mem_pipe_pkg::dmem_words];
  logic [3:0]                       shadow_tlb_v;
  logic [26:0]                      shadow_vtag [4];
  mem_pipe_pkg::pte_leaf_s          shadow_entry [4];
  int                               shadow_victim;
  mem_pipe_pkg::trans_info_s        model_trans;
  bit                               drained;
  int                               total_errors;
  logic [2:0]                       f3;
  logic [63:0]                      addr;

  mem_pipe dut (.*);

  mem_pipe_checker result_checker
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.result_v_i(result_v_o)
     ,.result_i(result_o)
     );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = next_bit();
    return v;
  endfunction

  function automatic logic [63:0] aligned_addr(input logic [1:0] size);
    logic [63:0] a;
    a = rand_bits(12);
    return (a >> size) << size;
  endfunction

  function automatic logic [63:0] vaddr(input logic [26:0] vtag, input logic [11:0] off);
    return {25'b0, vtag, off};
  endfunction

  function automatic mem_pipe_pkg::mem_result_s expected_result
    (input logic store, input logic [2:0] f3_i, input logic [63:0] ea, input logic [63:0] wdata);
    mem_pipe_pkg::mem_result_s r;
    mem_pipe_pkg::pte_leaf_s   e;
    int                        nbytes;
    int                        idx;
    int                        off;
    logic                      mis;
    logic                      noncanon;
    logic                      hit;
    logic                      pf;
    logic                      af;
    logic [63:0]               word;
    r = '0;
    e = '0;
    nbytes = 1 << f3_i[1:0];
    mis = (ea[2:0] & 3'(nbytes - 1)) != 3'b0;
    noncanon = ea[63:39] != {25{ea[38]}};
    hit = 1'b0;
    if (!model_trans.translation_en) begin
      hit = 1'b1;
      e.ptag = ea[21:12];
      e.u = 1'b1;
      e.w = 1'b1;
      e.d = 1'b1;
    end else if (!noncanon) begin
      for (int i = 0; i < 4; i++) begin
        if (!hit && shadow_tlb_v[i] && shadow_vtag[i] == ea[38:12]) begin
          hit = 1'b1;
          e = shadow_entry[i];
        end
      end
      r.tlb_miss = !hit;
    end
    pf = 1'b0;
    if (model_trans.translation_en && !mis) begin
      if (noncanon) pf = 1'b1;
      else if (hit) begin
        if (model_trans.priv_mode == mem_pipe_pkg::e_priv_user && !e.u) pf = 1'b1;
        else if (model_trans.priv_mode == mem_pipe_pkg::e_priv_supervisor && e.u
                 && !model_trans.mstatus_sum) pf = 1'b1;
        else if (store && (!e.w || !e.d)) pf = 1'b1;
      end
    end
    af = hit && !mis && !pf && (e.ptag != 10'd0);
    r.faults.load_misaligned    = mis && !store;
    r.faults.store_misaligned   = mis && store;
    r.faults.load_page_fault    = pf && !store;
    r.faults.store_page_fault   = pf && store;
    r.faults.load_access_fault  = af && !store;
    r.faults.store_access_fault = af && store;
    if (hit && !mis && !pf && !af) begin
      idx = ea[11:3];
      off = ea[2:0];
      if (store) begin
        for (int b = 0; b < nbytes; b++) shadow_mem[idx][(off+b)*8 +: 8] = wdata[b*8 +: 8];
      end else begin
        word = shadow_mem[idx] >> (off * 8);
        case (f3_i)
          3'd0: r.data = {{56{word[7]}}, word[7:0]};
          3'd1: r.data = {{48{word[15]}}, word[15:0]};
          3'd2: r.data = {{32{word[31]}}, word[31:0]};
          3'd4: r.data = {56'b0, word[7:0]};
          3'd5: r.data = {48'b0, word[15:0]};
          3'd6: r.data = {32'b0, word[31:0]};
          default: r.data = word;
        endcase
      end
    end
    return r;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      res_v_i  = 1'b0;
      fill_v_i = 1'b0;
      sfence_i = 1'b0;
    end
  endtask

  task automatic issue(input logic store, input logic [2:0] f3_i, input logic [63:0] ea,
                       input logic [63:0] wdata);
    logic [11:0]             imm;
    logic [63:0]             rs1;
    mem_pipe_pkg::rv_instr_u instr;
    imm = rand_bits(12);
    rs1 = ea - {{52{imm[11]}}, imm};
    if (store) instr = {imm[11:5], 5'd3, 5'd1, f3_i, imm[4:0], mem_pipe_pkg::opcode_store};
    else instr = {imm, 5'd1, f3_i, 5'd2, mem_pipe_pkg::opcode_load};
    @(negedge clk_i);
    res_v_i   = 1'b1;
    fill_v_i  = 1'b0;
    sfence_i  = 1'b0;
    res_i.instr = instr;
    res_i.rs1 = rs1;
    res_i.rs2 = wdata;
    result_checker.push_expected(expected_result(store, f3_i, ea, wdata));
  endtask

  task automatic fill_tlb(input logic [26:0] vtag, input logic [9:0] ptag,
                          input logic u, input logic w, input logic d);
    @(negedge clk_i);
    res_v_i  = 1'b0;
    sfence_i = 1'b0;
    fill_v_i = 1'b1;
    fill_i   = {vtag, ptag, u, w, d};
    shadow_tlb_v[shadow_victim] = 1'b1;
    shadow_vtag[shadow_victim]  = vtag;
    shadow_entry[shadow_victim] = {ptag, u, w, d};
    shadow_victim = (shadow_victim + 1) % 4;
  endtask

  task automatic sfence();
    @(negedge clk_i);
    res_v_i  = 1'b0;
    fill_v_i = 1'b0;
    sfence_i = 1'b1;
    shadow_tlb_v = '0;
  endtask

  task automatic set_trans(input logic en, input mem_pipe_pkg::priv_e priv, input logic sum);
    idle(4);
    trans_info_i = {en, priv, sum};
    model_trans  = trans_info_i;
  endtask

  initial begin
    reset_i = 1'b1;
    res_v_i = 1'b0;
    res_i = '0;
    fill_v_i = 1'b0;
    fill_i = '0;
    sfence_i = 1'b0;
    trans_info_i = {1'b0, mem_pipe_pkg::e_priv_machine, 1'b0};
    model_trans = trans_info_i;
    shadow_tlb_v = '0;
    shadow_victim = 0;
    for (int i = 0; i < mem_pipe_pkg::dmem_words; i++) shadow_mem[i] = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Bare mode, store then load of the same location back to back
    repeat (40) begin
      f3 = 3'(rand_bits(2));
      addr = aligned_addr(f3[1:0]);
      issue(1'b1, f3, addr, rand_bits(64));
      f3[1:0] = rand_bits(2);
      f3[2] = (f3[1:0] != 2'd3) ? rand_bits(1) : 1'b0;
      issue(1'b0, f3, (addr >> f3[1:0]) << f3[1:0], 64'd0);
    end
    issue(1'b0, 3'd3, 64'h1000, 64'd0);

    // Misaligned accesses
    repeat (12) begin
      f3 = {1'b0, 2'(rand_bits(1)) + 2'd1};
      addr = aligned_addr(2'd3) | 64'd1;
      issue(1'b1, f3, addr, rand_bits(64));
      issue(1'b0, 3'd3, addr & ~64'd7, 64'd0);
      issue(1'b0, f3, addr, 64'd0);
    end
    idle(1);

    set_trans(1'b1, mem_pipe_pkg::e_priv_supervisor, 1'b1);
    issue(1'b0, 3'd3, vaddr(27'd5, 12'h040), 64'd0);
    fill_tlb(27'd5, 10'd0, 1'b0, 1'b1, 1'b1);
    fill_tlb(27'd6, 10'd3, 1'b1, 1'b1, 1'b1);
    fill_tlb(27'd7, 10'd0, 1'b1, 1'b1, 1'b1);
    fill_tlb(27'd8, 10'd0, 1'b0, 1'b0, 1'b1);
    issue(1'b1, 3'd3, vaddr(27'd5, 12'h040), rand_bits(64));
    issue(1'b0, 3'd2, vaddr(27'd5, 12'h044), 64'd0);
    issue(1'b0, 3'd1, vaddr(27'd6, 12'h010), 64'd0);
    issue(1'b0, 3'd0, vaddr(27'd7, 12'h011), 64'd0);
    issue(1'b1, 3'd0, vaddr(27'd8, 12'h020), 64'hab);
    issue(1'b0, 3'd3, 64'h0000_0080_0000_0000, 64'd0);

    set_trans(1'b1, mem_pipe_pkg::e_priv_supervisor, 1'b0);
    issue(1'b0, 3'd0, vaddr(27'd7, 12'h011), 64'd0);
    issue(1'b0, 3'd0, vaddr(27'd5, 12'h041), 64'd0);
    set_trans(1'b1, mem_pipe_pkg::e_priv_user, 1'b0);
    issue(1'b0, 3'd4, vaddr(27'd5, 12'h042), 64'd0);
    issue(1'b1, 3'd1, vaddr(27'd7, 12'h012), rand_bits(64));
    issue(1'b0, 3'd5, vaddr(27'd7, 12'h012), 64'd0);

    // Fifth fill takes the oldest slot, a page without d
    fill_tlb(27'd9, 10'd0, 1'b1, 1'b1, 1'b0);
    issue(1'b1, 3'd2, vaddr(27'd9, 12'h100), rand_bits(64));
    issue(1'b0, 3'd3, vaddr(27'd5, 12'h040), 64'd0);
    issue(1'b0, 3'd6, vaddr(27'd7, 12'h010), 64'd0);
    sfence();
    issue(1'b0, 3'd3, vaddr(27'd6, 12'h000), 64'd0);
    issue(1'b0, 3'd3, vaddr(27'd7, 12'h000), 64'd0);
    issue(1'b1, 3'd3, vaddr(27'd9, 12'h108), rand_bits(64));
    idle(1);

    result_checker.wait_drained(50, drained);
    total_errors = result_checker.data_errors + result_checker.flag_errors
                   + result_checker.protocol_errors;
    if (!drained) begin
      $display("Timed out with %0d expected results never returned",
               result_checker.expected_q.size());
      total_errors++;
    end
    $display("Checked %0d results: data errors %0d, flag errors %0d, protocol errors %0d",
             result_checker.checked, result_checker.data_errors,
             result_checker.flag_errors, result_checker.protocol_errors);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: mem_pipe_assert.sv
// Protocol and fault rules on the memory pipe ports
`timescale 1ns/100ps

module mem_pipe_assert
  (input                               clk_i
   , input                             reset_i
   , input                             res_v_i
   , input                             fill_v_i
   , input                             result_v_o
   , input  mem_pipe_pkg::mem_result_s result_o
   );

  no_fill_with_res: assert property (@(posedge clk_i) disable iff (reset_i)
    !(res_v_i && fill_v_i)) else $error("res_v_i and fill_v_i high together");

  res_to_result: assert property (@(posedge clk_i) disable iff (reset_i)
    res_v_i |-> ##2 result_v_o) else $error("result_v_o missing two cycles after res_v_i");

  result_from_res: assert property (@(posedge clk_i) disable iff (reset_i)
    result_v_o |-> $past(res_v_i, 2)) else $error("result_v_o without a matching res_v_i");

  quiet_in_reset: assert property (@(posedge clk_i)
    reset_i |=> !result_v_o) else $error("result_v_o high during reset");

  single_fault: assert property (@(posedge clk_i) disable iff (reset_i)
    result_v_o |-> $onehot0(result_o.faults)) else $error("more than one fault flag set");

endmodule

bind mem_pipe mem_pipe_assert asrt (.*);

// File: mem_pipe_checker.sv
// Result checker, compares each DUT result against the queued model result
`timescale 1ns/100ps

module mem_pipe_checker
  (input                               clk_i
   , input                             reset_i
   , input                             result_v_i
   , input  mem_pipe_pkg::mem_result_s result_i
   );

  mem_pipe_pkg::mem_result_s expected_q [$];
  mem_pipe_pkg::mem_result_s exp_r;

  int data_errors     = 0;
  int flag_errors     = 0;
  int protocol_errors = 0;
  int checked         = 0;

  function automatic void push_expected(input mem_pipe_pkg::mem_result_s r);
    expected_q.push_back(r);
  endfunction

  function automatic void check_field(input string name, input logic [63:0] exp_v,
                                      input logic [63:0] act_v, input bit is_data);
    if (act_v !== exp_v) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
      if (is_data) data_errors++;
      else flag_errors++;
    end
  endfunction

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk_i) begin
    if (!reset_i && result_v_i === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("Result strobe at %0t arrived with no expected result queued", $time);
        protocol_errors++;
      end else begin
        exp_r = expected_q.pop_front();
        checked++;
        check_field("result_o.data", exp_r.data, result_i.data, 1'b1);
        check_field("result_o.faults.load_page_fault", 64'(exp_r.faults.load_page_fault),
                    64'(result_i.faults.load_page_fault), 1'b0);
        check_field("result_o.faults.store_page_fault", 64'(exp_r.faults.store_page_fault),
                    64'(result_i.faults.store_page_fault), 1'b0);
        check_field("result_o.faults.load_access_fault", 64'(exp_r.faults.load_access_fault),
                    64'(result_i.faults.load_access_fault), 1'b0);
        check_field("result_o.faults.store_access_fault",
                    64'(exp_r.faults.store_access_fault),
                    64'(result_i.faults.store_access_fault), 1'b0);
        check_field("result_o.faults.load_misaligned", 64'(exp_r.faults.load_misaligned),
                    64'(result_i.faults.load_misaligned), 1'b0);
        check_field("result_o.faults.store_misaligned", 64'(exp_r.faults.store_misaligned),
                    64'(result_i.faults.store_misaligned), 1'b0);
        check_field("result_o.tlb_miss", 64'(exp_r.tlb_miss), 64'(result_i.tlb_miss), 1'b0);
      end
    end
  end

  task automatic wait_drained(input int max_cycles, output bit drained);
    int n;
    n = 0;
    while (expected_q.size() != 0 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    drained = (expected_q.size() == 0);
  endtask

endmodule

// File: mem_pipe.sv
// Memory instruction pipe with address generation, translation, fault checks and data access
`timescale 1ns/100ps

module mem_pipe
  (input                                   clk_i
   , input                                 reset_i

   , input                                 res_v_i
   , input  mem_pipe_pkg::mem_reservation_s res_i

   , input                                 fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s       fill_i
   , input                                 sfence_i

   , input  mem_pipe_pkg::trans_info_s     trans_info_i

   , output logic                          result_v_o
   , output mem_pipe_pkg::mem_result_s     result_o
   );

  mem_pipe_pkg::rv_instr_u               instr;
  logic                                  is_store_mem0;
  logic [2:0]                            funct3_mem0;
  logic [11:0]                           imm12_mem0;
  logic [mem_pipe_pkg::dword_width-1:0]  eaddr_mem0;
  logic                                  noncanon_mem0;
  mem_pipe_pkg::mem_op_s                 op_mem0;
  logic                                  lookup_v;

  logic                                  req_v_mem1;
  mem_pipe_pkg::mem_op_s                 op_mem1;
  logic [mem_pipe_pkg::vaddr_width-1:0]  eaddr_mem1;
  logic [mem_pipe_pkg::dword_width-1:0]  rs2_mem1;
  logic                                  noncanon_mem1;

  logic                                  tlb_hit_v;
  logic                                  tlb_miss_v;
  mem_pipe_pkg::pte_leaf_s               tlb_entry;
  mem_pipe_pkg::pte_leaf_s               passthrough_entry;
  mem_pipe_pkg::pte_leaf_s               entry_mem1;
  logic                                  entry_v_mem1;
  mem_pipe_pkg::mem_faults_s             faults_mem1;
  logic                                  tlb_miss_mem1;
  logic                                  dmem_v;

  mem_pipe_pkg::mem_faults_s             faults_mem2;
  logic                                  tlb_miss_mem2;
  logic [mem_pipe_pkg::dword_width-1:0]  dmem_data;

  // Decode in mem0 through the view the opcode selects
  assign instr         = res_i.instr;
  assign is_store_mem0 = (instr.stype.opcode == mem_pipe_pkg::opcode_store);
  // funct3 sits in the same bits in both views
  assign funct3_mem0   = instr.itype.funct3;
  assign imm12_mem0    = is_store_mem0 ? {instr.stype.imm_hi, instr.stype.imm_lo}
                                       : instr.itype.imm;

  assign op_mem0.store       = is_store_mem0;
  assign op_mem0.size        = mem_pipe_pkg::mem_size_e'(funct3_mem0[1:0]);
  assign op_mem0.is_unsigned = (instr.itype.opcode == mem_pipe_pkg::opcode_load)
                               & funct3_mem0[2];

  assign eaddr_mem0 = res_i.rs1
                      + {{(mem_pipe_pkg::dword_width-12){imm12_mem0[11]}}, imm12_mem0};

  // Upper bits must repeat bit 38 under Sv39
  assign noncanon_mem0 =
    eaddr_mem0[mem_pipe_pkg::dword_width-1:mem_pipe_pkg::vaddr_width]
    != {(mem_pipe_pkg::dword_width-mem_pipe_pkg::vaddr_width){
         eaddr_mem0[mem_pipe_pkg::vaddr_width-1]}};

  assign lookup_v = res_v_i & trans_info_i.translation_en & ~noncanon_mem0;

  mem_dtlb dtlb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(sfence_i)
     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)
     ,.lookup_v_i(lookup_v)
     ,.vtag_i(eaddr_mem0[mem_pipe_pkg::page_offset_width+:mem_pipe_pkg::vtag_width])
     ,.hit_v_o(tlb_hit_v)
     ,.miss_v_o(tlb_miss_v)
     ,.entry_o(tlb_entry)
     );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_v_mem1 <= 1'b0;
    end else begin
      req_v_mem1 <= res_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_v_i) begin
      op_mem1       <= op_mem0;
      eaddr_mem1    <= eaddr_mem0[mem_pipe_pkg::vaddr_width-1:0];
      rs2_mem1      <= res_i.rs2;
      noncanon_mem1 <= noncanon_mem0;
    end
  end

  // Bare mode in mem1 maps the address straight onto a fully permitted page
  assign passthrough_entry.ptag =
    eaddr_mem1[mem_pipe_pkg::page_offset_width+:mem_pipe_pkg::ptag_width];
  assign passthrough_entry.u = 1'b1;
  assign passthrough_entry.w = 1'b1;
  assign passthrough_entry.d = 1'b1;

  assign entry_mem1    = trans_info_i.translation_en ? tlb_entry : passthrough_entry;
  assign entry_v_mem1  = trans_info_i.translation_en ? tlb_hit_v : req_v_mem1;
  assign tlb_miss_mem1 = trans_info_i.translation_en & tlb_miss_v;

  mem_fault_check fault_check
    (.req_v_i(req_v_mem1)
     ,.op_i(op_mem1)
     ,.eaddr_low_i(eaddr_mem1[2:0])
     ,.noncanon_i(noncanon_mem1)
     ,.entry_v_i(entry_v_mem1)
     ,.entry_i(entry_mem1)
     ,.trans_i(trans_info_i)
     ,.faults_o(faults_mem1)
     );

  assign dmem_v = req_v_mem1 & entry_v_mem1 & ~(|faults_mem1);

  // Only the data page is backed, so the page offset picks the location
  mem_dmem dmem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(dmem_v)
     ,.op_i(op_mem1)
     ,.addr_i(eaddr_mem1[mem_pipe_pkg::page_offset_width-1:0])
     ,.wdata_i(rs2_mem1)
     ,.data_o(dmem_data)
     );

  // mem2
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_v_o <= 1'b0;
    end else begin
      result_v_o <= req_v_mem1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_mem1) begin
      faults_mem2   <= faults_mem1;
      tlb_miss_mem2 <= tlb_miss_mem1;
    end
  end

  assign result_o.data     = dmem_data;
  assign result_o.faults   = faults_mem2;
  assign result_o.tlb_miss = tlb_miss_mem2;

endmodule

// File: mem_dmem.sv
// Tightly coupled 4 KiB data memory with byte-lane stores and extended load data
`timescale 1ns/100ps

module mem_dmem
  (input                                          clk_i
   , input                                        reset_i

   , input                                        v_i
   , input  mem_pipe_pkg::mem_op_s                op_i
   , input  [mem_pipe_pkg::page_offset_width-1:0] addr_i
   , input  [mem_pipe_pkg::dword_width-1:0]       wdata_i

   , output logic [mem_pipe_pkg::dword_width-1:0] data_o
   );

  logic [mem_pipe_pkg::dword_width-1:0]         mem_r [mem_pipe_pkg::dmem_words];

  logic [mem_pipe_pkg::page_offset_width-4:0]   idx;
  logic [5:0]                                   bit_shift;
  logic [7:0]                                   size_mask;
  logic [7:0]                                   lanes;
  logic [mem_pipe_pkg::dword_width-1:0]         wdata_shifted;
  logic [mem_pipe_pkg::dword_width-1:0]         rdata_shifted;
  logic [mem_pipe_pkg::dword_width-1:0]         load_data;

  initial begin
    for (int i = 0; i < mem_pipe_pkg::dmem_words; i++) begin
      mem_r[i] = '0;
    end
  end

  assign idx       = addr_i[mem_pipe_pkg::page_offset_width-1:3];
  assign bit_shift = {addr_i[2:0], 3'b000};

  always_comb begin
    unique case (op_i.size)
      mem_pipe_pkg::e_size_byte: size_mask = 8'h01;
      mem_pipe_pkg::e_size_half: size_mask = 8'h03;
      mem_pipe_pkg::e_size_word: size_mask = 8'h0f;
      default:                   size_mask = 8'hff;
    endcase
  end

  assign lanes         = size_mask << addr_i[2:0];
  assign wdata_shifted = wdata_i << bit_shift;

  always_ff @(posedge clk_i) begin
    if (v_i && op_i.store) begin
      for (int b = 0; b < 8; b++) begin
        if (lanes[b]) begin
          mem_r[idx][b*8+:8] <= wdata_shifted[b*8+:8];
        end
      end
    end
  end

  // Sign comes from the top bit of the accessed field
  assign rdata_shifted = mem_r[idx] >> bit_shift;

  always_comb begin
    unique case (op_i.size)
      mem_pipe_pkg::e_size_byte:
        load_data = {{56{~op_i.is_unsigned & rdata_shifted[7]}}, rdata_shifted[7:0]};
      mem_pipe_pkg::e_size_half:
        load_data = {{48{~op_i.is_unsigned & rdata_shifted[15]}}, rdata_shifted[15:0]};
      mem_pipe_pkg::e_size_word:
        load_data = {{32{~op_i.is_unsigned & rdata_shifted[31]}}, rdata_shifted[31:0]};
      default:
        load_data = rdata_shifted;
    endcase
  end

  // Zero unless a load was performed
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_o <= '0;
    end else if (v_i && !op_i.store) begin
      data_o <= load_data;
    end else begin
      data_o <= '0;
    end
  end

endmodule

// File: mem_fault_check.sv
// Misalignment, page fault and access fault detection for a mem1 request
`timescale 1ns/100ps

module mem_fault_check
  (input                                req_v_i
   , input  mem_pipe_pkg::mem_op_s      op_i
   , input  [2:0]                       eaddr_low_i
   , input                              noncanon_i
   , input                              entry_v_i
   , input  mem_pipe_pkg::pte_leaf_s    entry_i
   , input  mem_pipe_pkg::trans_info_s  trans_i
   , output mem_pipe_pkg::mem_faults_s  faults_o
   );

  logic misaligned;
  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic access_fault;

  always_comb begin
    unique case (op_i.size)
      mem_pipe_pkg::e_size_byte: misaligned = 1'b0;
      mem_pipe_pkg::e_size_half: misaligned = eaddr_low_i[0];
      mem_pipe_pkg::e_size_word: misaligned = |eaddr_low_i[1:0];
      default:                   misaligned = |eaddr_low_i;
    endcase
  end

  // User pages are off limits to S mode unless SUM is set
  assign priv_fault =
    ((trans_i.priv_mode == mem_pipe_pkg::e_priv_user) & ~entry_i.u)
    | ((trans_i.priv_mode == mem_pipe_pkg::e_priv_supervisor) & entry_i.u
       & ~trans_i.mstatus_sum);

  assign write_fault = op_i.store & (~entry_i.w | ~entry_i.d);

  // Misalignment outranks page faults, both outrank access faults
  assign page_fault = req_v_i & trans_i.translation_en & ~misaligned
                      & (noncanon_i | (entry_v_i & (priv_fault | write_fault)));

  assign access_fault = req_v_i & entry_v_i & ~misaligned & ~page_fault
                        & (entry_i.ptag != mem_pipe_pkg::dmem_ptag);

  always_comb begin
    faults_o.load_page_fault    = page_fault & ~op_i.store;
    faults_o.store_page_fault   = page_fault & op_i.store;
    faults_o.load_access_fault  = access_fault & ~op_i.store;
    faults_o.store_access_fault = access_fault & op_i.store;
    faults_o.load_misaligned    = req_v_i & misaligned & ~op_i.store;
    faults_o.store_misaligned   = req_v_i & misaligned & op_i.store;
  end

endmodule

// File: mem_dtlb.sv
// Data TLB, four fully associative entries with round-robin fill and a registered lookup
`timescale 1ns/100ps

module mem_dtlb
  (input                                          clk_i
   , input                                        reset_i
   , input                                        flush_i

   , input                                        fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s              fill_i

   , input                                        lookup_v_i
   , input  [mem_pipe_pkg::vtag_width-1:0]        vtag_i

   , output logic                                 hit_v_o
   , output logic                                 miss_v_o
   , output mem_pipe_pkg::pte_leaf_s              entry_o
   );

  logic [mem_pipe_pkg::dtlb_els-1:0]       valid_r;
  logic [mem_pipe_pkg::vtag_width-1:0]     vtag_r [mem_pipe_pkg::dtlb_els];
  mem_pipe_pkg::pte_leaf_s                 entry_r [mem_pipe_pkg::dtlb_els];
  logic [mem_pipe_pkg::dtlb_idx_width-1:0] victim_r;

  logic                                    match_v;
  logic [mem_pipe_pkg::dtlb_idx_width-1:0] match_idx;

  // Parallel compare, lowest index wins on duplicate tags
  always_comb begin
    match_v   = 1'b0;
    match_idx = '0;
    for (int i = mem_pipe_pkg::dtlb_els - 1; i >= 0; i--) begin
      if (valid_r[i] && (vtag_r[i] == vtag_i)) begin
        match_v   = 1'b1;
        match_idx = mem_pipe_pkg::dtlb_idx_width'(i);
      end
    end
  end

  // Flush beats a fill in the same cycle; the victim pointer survives a flush
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[victim_r] <= 1'b1;
      victim_r          <= victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i && !flush_i) begin
      vtag_r[victim_r]  <= fill_i.vtag;
      entry_r[victim_r] <= fill_i.entry;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_v_o  <= 1'b0;
      miss_v_o <= 1'b0;
    end else begin
      hit_v_o  <= lookup_v_i & match_v;
      miss_v_o <= lookup_v_i & ~match_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      entry_o <= entry_r[match_idx];
    end
  end

endmodule

// File: mem_pipe_pkg.sv
// Shared widths, opcodes, instruction views and stage payloads for the memory pipe
package mem_pipe_pkg;

  localparam int vaddr_width       = 39;
  localparam int paddr_width       = 22;
  localparam int page_offset_width = 12;
  localparam int vtag_width        = 27;
  localparam int ptag_width        = 10;
  localparam int dword_width       = 64;
  localparam int dtlb_els          = 4;
  localparam int dtlb_idx_width    = $clog2(dtlb_els);
  localparam int dmem_words        = 512;

  // Physical page that holds the data memory
  localparam logic [ptag_width-1:0] dmem_ptag = '0;

  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  typedef enum logic [1:0] {
    e_priv_user       = 2'b00,
    e_priv_supervisor = 2'b01,
    e_priv_machine    = 2'b11
  } priv_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    e_size_byte   = 2'b00,
    e_size_half   = 2'b01,
    e_size_word   = 2'b10,
    e_size_double = 2'b11
  } mem_size_e;

  typedef struct packed {
    logic      store;
    mem_size_e size;
    logic      is_unsigned;
  } mem_op_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_itype_s;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_stype_s;

  // Opcode selects the view
  typedef union packed {
    rv_itype_s itype;
    rv_stype_s stype;
  } rv_instr_u;

  typedef struct packed {
    rv_instr_u              instr;
    logic [dword_width-1:0] rs1;
    logic [dword_width-1:0] rs2;
  } mem_reservation_s;

  typedef struct packed {
    logic  translation_en;
    priv_e priv_mode;
    logic  mstatus_sum;
  } trans_info_s;

  typedef struct packed {
    logic [ptag_width-1:0] ptag;
    logic                  u;
    logic                  w;
    logic                  d;
  } pte_leaf_s;

  typedef struct packed {
    logic [vtag_width-1:0] vtag;
    pte_leaf_s             entry;
  } tlb_fill_s;

  typedef struct packed {
    logic load_page_fault;
    logic store_page_fault;
    logic load_access_fault;
    logic store_access_fault;
    logic load_misaligned;
    logic store_misaligned;
  } mem_faults_s;

  typedef struct packed {
    logic [dword_width-1:0] data;
    mem_faults_s            faults;
    logic                   tlb_miss;
  } mem_result_s;

endpackage
